// File: build.f
logic/axi_pkg.sv
logic/line_req_pkg.sv
logic/line_arbiter.sv
logic/axi_line_master.sv
logic/mem_bus_top.sv
dv/axi_mem_model.sv
dv/mem_bus_tb.sv

// File: dv/axi_mem_model.sv
// AXI4 slave memory for simulation, with stall inputs for back-pressure and an error region
`default_nettype none
`timescale 1ns/1ps

module axi_mem_model (
  input  logic               i_aclk,
  input  logic               i_rst,
  input  logic [3:0]         i_stall,              // aw, w, ar, r or b
  input  axi_pkg::axi_aw_t   i_aw,
  input  logic               i_awvalid,
  output logic               o_awready,
  input  axi_pkg::axi_w_t    i_w,
  input  logic               i_wvalid,
  output logic               o_wready,
  output axi_pkg::axi_resp_e o_bresp,
  output logic               o_bvalid,
  input  logic               i_bready,
  input  axi_pkg::axi_ar_t   i_ar,
  input  logic               i_arvalid,
  output logic               o_arready,
  output axi_pkg::axi_r_t    o_r,
  output logic               o_rvalid,
  input  logic               i_rready
);
  import axi_pkg::*;

  axi_data_t  mem [axi_addr_t];                    // only words written so far
  logic       wr_act_q;
  axi_addr_t  wr_addr_q;
  logic       b_pend_q;
  logic       b_err_q;
  logic       rd_act_q;
  axi_addr_t  rd_addr_q;
  logic [1:0] rd_beat_q;

  // untouched words hold their own address in both halves
  function automatic axi_data_t word_at(input axi_addr_t a);
    if (mem.exists(a)) return mem[a];
    return {a, a};
  endfunction

  function automatic axi_data_t merge_bytes(input axi_data_t old, input axi_data_t data,
                                            input axi_strb_t strb);
    axi_data_t res;
    res = old;
    for (int b = 0; b < AXI_STRB_W; b++) begin
      if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  assign o_awready = !wr_act_q && !b_pend_q && !o_bvalid && !i_stall[0];
  assign o_wready  = wr_act_q && !i_stall[1];
  assign o_arready = !rd_act_q && !o_rvalid && !i_stall[2];

  // ----------------------------------------
  // write path
  // ----------------------------------------
  always @(posedge i_aclk) begin
    if (!i_rst && i_wvalid && o_wready && !wr_addr_q[31]) begin
      mem[wr_addr_q] = merge_bytes(word_at(wr_addr_q), i_w.data, i_w.strb);
    end
  end

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      wr_act_q <= 1'b0;
      b_pend_q <= 1'b0;
      b_err_q  <= 1'b0;
      o_bvalid <= 1'b0;
      o_bresp  <= OKAY;
    end else begin
      if (i_awvalid && o_awready) begin
        wr_act_q  <= 1'b1;
        wr_addr_q <= i_aw.addr;
      end
      if (i_wvalid && o_wready) begin
        wr_addr_q <= wr_addr_q + 32'd8;
        if (i_w.last) begin
          wr_act_q <= 1'b0;
          b_pend_q <= 1'b1;
          b_err_q  <= wr_addr_q[31];             // error region
        end
      end
      if (b_pend_q && !i_stall[3]) begin
        o_bvalid <= 1'b1;
        o_bresp  <= b_err_q ? SLVERR : OKAY;
        b_pend_q <= 1'b0;
      end else if (o_bvalid && i_bready) begin
        o_bvalid <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // read path
  // ----------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      rd_act_q  <= 1'b0;
      rd_beat_q <= '0;
      o_rvalid  <= 1'b0;
      o_r       <= '0;
    end else begin
      if (i_arvalid && o_arready) begin
        rd_act_q  <= 1'b1;
        rd_addr_q <= i_ar.addr;
        rd_beat_q <= '0;
      end
      if (o_rvalid && i_rready) o_rvalid <= 1'b0;
      if (rd_act_q && (!o_rvalid || i_rready) && !i_stall[3]) begin
        o_rvalid  <= 1'b1;                        // next beat, old one taken
        o_r       <= '{data: rd_addr_q[31] ? '0 : word_at(rd_addr_q),
                       resp: rd_addr_q[31] ? SLVERR : OKAY,
                       last: rd_beat_q == 2'd3};
        rd_addr_q <= rd_addr_q + 32'd8;
        rd_beat_q <= rd_beat_q + 2'd1;
        if (rd_beat_q == 2'd3) rd_act_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/mem_bus_tb.sv
// testbench for the memory-side bus; drives both cache ports and checks line data and AXI rules
`default_nettype none
`timescale 1ns/1ps

module mem_bus_tb;
  import axi_pkg::*;
  import line_req_pkg::*;

  localparam int          NUM_TXNS  = 19;
  localparam int          CYCLE_NS  = 100;
  localparam logic [31:0] LFSR_SEED = 32'haf8d_e882;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;    // x^32 + x^22 + x^2 + x + 1

  logic       i_aclk, i_rst, i_ic_req, o_ic_rsp, i_dc_req, o_dc_rsp;
  line_addr_t i_ic_addr;
  line_req_t  i_dc_req_data;
  line_rsp_t  o_ic_rsp_data, o_dc_rsp_data;
  axi_aw_t    o_aw;
  axi_w_t     o_w;
  axi_ar_t    o_ar;
  axi_r_t     i_r;
  axi_resp_e  i_bresp;
  logic       o_awvalid, i_awready, o_wvalid, i_wready, i_bvalid, o_bready;
  logic       o_arvalid, i_arready, i_rvalid, o_rready;
  logic [3:0] stall;                                    // memory back-pressure this cycle

  logic [31:0] stim_lfsr;
  logic [31:0] stall_lfsr;
  axi_data_t   shadow [axi_addr_t];                     // words written so far
  req_id_e     last_port;
  string       test_name;
  logic        aw_hold, w_hold, ar_hold;
  axi_aw_t     aw_prev;
  axi_w_t      w_prev;
  axi_ar_t     ar_prev;
  logic [1:0]  w_beats;
  logic        rd_open;                                 // AR taken, rlast not yet
  logic        b_open;                                  // wlast taken, B not yet

  mem_bus_top dut0 (.*);

  axi_mem_model mem0 (
    .i_aclk    (i_aclk),
    .i_rst     (i_rst),
    .i_stall   (stall),
    .i_aw      (o_aw),
    .i_awvalid (o_awvalid),
    .o_awready (i_awready),
    .i_w       (o_w),
    .i_wvalid  (o_wvalid),
    .o_wready  (i_wready),
    .o_bresp   (i_bresp),
    .o_bvalid  (i_bvalid),
    .i_bready  (o_bready),
    .i_ar      (o_ar),
    .i_arvalid (o_arvalid),
    .o_arready (i_arready),
    .o_r       (i_r),
    .o_rvalid  (i_rvalid),
    .i_rready  (o_rready)
  );

  // ----------------------------------------
  // failure reporting
  // ----------------------------------------
  task automatic stop_failed();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic value_error(input string name, input logic [255:0] exp, input logic [255:0] act);
    $display("ERROR %s: expected %h actual %h", name, exp, act);
    stop_failed();
  endtask

  task automatic plain_error(input string msg);
    $display("%s", msg);
    stop_failed();
  endtask

  // ----------------------------------------
  // random numbers and shadow memory
  // ----------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [255:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i]      = stim_lfsr[0];
      stim_lfsr = lfsr_step(stim_lfsr);
    end
  endtask

  task automatic rand_addr(input logic high, output line_addr_t la);
    logic [255:0] v;
    take_bits(LINE_ADDR_W - 1, v);
    la = {high, v[LINE_ADDR_W-2:0]};                    // high selects the error region
  endtask

  task automatic rand_write(input line_addr_t la, output line_req_t rq);
    logic [255:0] data;
    logic [255:0] mask;
    take_bits(LINE_W, data);
    take_bits(LINE_BYTES, mask);
    rq = '{op: LINE_WRITE, addr: la, wdata: data, mask: mask[LINE_BYTES-1:0]};
  endtask

  function automatic axi_data_t shadow_word(input axi_addr_t a);
    if (shadow.exists(a)) return shadow[a];
    return {a, a};                                      // fill rule
  endfunction

  function automatic line_t shadow_line(input line_addr_t la);
    line_t l;
    for (int k = 0; k < AXI_BEATS_PER_LINE; k++) begin
      l[64*k +: 64] = shadow_word({la, 5'd0} + 32'(8 * k));
    end
    return l;
  endfunction

  task automatic shadow_write(input line_addr_t la, input line_t data, input line_mask_t mask);
    axi_addr_t a;
    axi_data_t word;
    for (int k = 0; k < AXI_BEATS_PER_LINE; k++) begin
      a    = {la, 5'd0} + 32'(8 * k);
      word = shadow_word(a);
      for (int b = 0; b < 8; b++) begin
        if (mask[8*k + b]) word[8*b +: 8] = data[64*k + 8*b +: 8];
      end
      shadow[a] = word;
    end
  endtask

  // ----------------------------------------
  // cache-side drivers
  // ----------------------------------------
  task automatic send_ic(input line_addr_t la);
    @(negedge i_aclk);
    i_ic_req  = 1'b1;
    i_ic_addr = la;
    @(negedge i_aclk);
    i_ic_req  = 1'b0;
  endtask

  task automatic send_dc(input line_req_t rq);
    @(negedge i_aclk);
    i_dc_req      = 1'b1;
    i_dc_req_data = rq;
    @(negedge i_aclk);
    i_dc_req      = 1'b0;
  endtask

  task automatic wait_rsp(input req_id_e port, output line_rsp_t rsp);
    @(negedge i_aclk);
    while (!((port == REQ_ICACHE) ? o_ic_rsp : o_dc_rsp)) @(negedge i_aclk);
    rsp       = (port == REQ_ICACHE) ? o_ic_rsp_data : o_dc_rsp_data;
    last_port = port;
  endtask

  task automatic check_rsp(input line_rsp_t rsp, input line_t exp_data, input logic exp_err,
                           input logic check_data);
    assert (rsp.err == exp_err) else value_error({test_name, " err"}, exp_err, rsp.err);
    if (check_data) begin
      assert (rsp.rdata == exp_data) else value_error({test_name, " rdata"}, exp_data, rsp.rdata);
    end
  endtask

  // both strobes in one cycle, the port not granted last answers first
  task automatic run_both(input line_addr_t ia, input line_addr_t da);
    req_id_e   expect_first;
    req_id_e   first;
    line_rsp_t rsp;
    expect_first = (last_port == REQ_ICACHE) ? REQ_DCACHE : REQ_ICACHE;
    @(negedge i_aclk);
    i_ic_req      = 1'b1;
    i_ic_addr     = ia;
    i_dc_req      = 1'b1;
    i_dc_req_data = '{op: LINE_READ, addr: da, wdata: '0, mask: '0};
    @(negedge i_aclk);
    i_ic_req = 1'b0;
    i_dc_req = 1'b0;
    @(negedge i_aclk);
    while (!o_ic_rsp && !o_dc_rsp) @(negedge i_aclk);
    assert (!(o_ic_rsp && o_dc_rsp)) else plain_error("both_ports: two response strobes at once");
    first = o_ic_rsp ? REQ_ICACHE : REQ_DCACHE;
    assert (first == expect_first) else value_error({test_name, " order"}, expect_first, first);
    rsp       = (first == REQ_ICACHE) ? o_ic_rsp_data : o_dc_rsp_data;
    last_port = first;
    check_rsp(rsp, shadow_line((first == REQ_ICACHE) ? ia : da), 1'b0, 1'b1);
    wait_rsp((first == REQ_ICACHE) ? REQ_DCACHE : REQ_ICACHE, rsp);
    check_rsp(rsp, shadow_line((first == REQ_ICACHE) ? da : ia), 1'b0, 1'b1);
  endtask

  // ----------------------------------------
  // clock, back-pressure, watchdog
  // ----------------------------------------
  initial begin
    i_aclk = 1'b0;
    forever #(CYCLE_NS / 2) i_aclk = ~i_aclk;
  end

  initial begin
    stall      = '0;
    stall_lfsr = LFSR_SEED;
    forever begin
      @(negedge i_aclk);
      for (int i = 0; i < 4; i++) begin
        stall[i]   = stall_lfsr[0];                     // one step per stall bit
        stall_lfsr = lfsr_step(stall_lfsr);
      end
    end
  end

  initial begin
    repeat (NUM_TXNS * 200) @(posedge i_aclk);
    plain_error("watchdog: transactions did not complete in the allowed time");
  end

  // ----------------------------------------
  // AXI rule monitor
  // ----------------------------------------
  always @(posedge i_aclk) begin
    if (i_rst) begin
      aw_hold <= 1'b0;
      w_hold  <= 1'b0;
      ar_hold <= 1'b0;
      w_beats <= '0;
      rd_open <= 1'b0;
      b_open  <= 1'b0;
    end else begin
      if (o_awvalid) begin
        assert (o_aw.len == 8'd3 && o_aw.burst == INCR)
          else value_error("axi_rules aw len burst", {8'd3, INCR}, {o_aw.len, o_aw.burst});
      end
      if (o_arvalid) begin
        assert (o_ar.len == 8'd3 && o_ar.burst == INCR)
          else value_error("axi_rules ar len burst", {8'd3, INCR}, {o_ar.len, o_ar.burst});
      end
      if (aw_hold) begin
        assert (o_awvalid && o_aw == aw_prev)
          else plain_error("axi_rules: AW valid or payload changed before awready");
      end
      if (w_hold) begin
        assert (o_wvalid && o_w == w_prev)
          else plain_error("axi_rules: W valid or payload changed before wready");
      end
      if (ar_hold) begin
        assert (o_arvalid && o_ar == ar_prev)
          else plain_error("axi_rules: AR valid or payload changed before arready");
      end
      if (o_wvalid && i_wready) begin
        assert (o_w.last == (w_beats == 2'd3))
          else value_error("axi_rules wlast", w_beats == 2'd3, o_w.last);
        w_beats <= w_beats + 2'd1;                      // wraps after the fourth beat
      end
      assert (o_rready == rd_open)
        else value_error("axi_rules rready", rd_open, o_rready);
      assert (o_bready == b_open)
        else value_error("axi_rules bready", b_open, o_bready);
      if (o_arvalid && i_arready) rd_open <= 1'b1;
      if (o_rready && i_rvalid && i_r.last) rd_open <= 1'b0;
      if (o_wvalid && i_wready && o_w.last) b_open <= 1'b1;
      if (o_bready && i_bvalid) b_open <= 1'b0;
      aw_hold <= o_awvalid && !i_awready;
      w_hold  <= o_wvalid && !i_wready;
      ar_hold <= o_arvalid && !i_arready;
      aw_prev <= o_aw;
      w_prev  <= o_w;
      ar_prev <= o_ar;
    end
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    line_addr_t la;
    line_addr_t wr_la;
    line_req_t  rq;
    line_rsp_t  rsp;
    i_rst         = 1'b1;
    i_ic_req      = 1'b0;
    i_ic_addr     = '0;
    i_dc_req      = 1'b0;
    i_dc_req_data = '0;
    stim_lfsr     = LFSR_SEED;
    last_port     = REQ_DCACHE;                         // first tie after reset goes to the icache
    repeat (2) @(posedge i_aclk);
    @(negedge i_aclk);
    i_rst = 1'b0;

    test_name = "icache_read";
    repeat (3) begin
      rand_addr(1'b0, la);
      send_ic(la);
      wait_rsp(REQ_ICACHE, rsp);
      check_rsp(rsp, shadow_line(la), 1'b0, 1'b1);
    end

    test_name = "dcache_write_read";
    repeat (4) begin
      rand_addr(1'b0, la);
      rand_write(la, rq);
      send_dc(rq);
      wait_rsp(REQ_DCACHE, rsp);
      check_rsp(rsp, '0, 1'b0, 1'b0);
      shadow_write(la, rq.wdata, rq.mask);
      rq = '{op: LINE_READ, addr: la, wdata: '0, mask: '0};
      send_dc(rq);
      wait_rsp(REQ_DCACHE, rsp);
      check_rsp(rsp, shadow_line(la), 1'b0, 1'b1);
    end
    wr_la = la;

    test_name = "both_ports";
    rand_addr(1'b0, la);
    run_both(wr_la, la);
    rand_addr(1'b0, la);
    send_ic(la);                                        // icache becomes last granted
    wait_rsp(REQ_ICACHE, rsp);
    check_rsp(rsp, shadow_line(la), 1'b0, 1'b1);
    rand_addr(1'b0, la);
    run_both(la, wr_la);

    test_name = "error_region";
    rand_addr(1'b1, la);
    rq = '{op: LINE_READ, addr: la, wdata: '0, mask: '0};
    send_dc(rq);
    wait_rsp(REQ_DCACHE, rsp);
    check_rsp(rsp, '0, 1'b1, 1'b0);
    rand_write(la, rq);
    send_dc(rq);
    wait_rsp(REQ_DCACHE, rsp);
    check_rsp(rsp, '0, 1'b1, 1'b0);
    rand_addr(1'b0, la);
    send_ic(la);
    wait_rsp(REQ_ICACHE, rsp);
    check_rsp(rsp, shadow_line(la), 1'b0, 1'b1);

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/axi_line_master.sv
// AXI4 master that runs one granted line request as a four-beat INCR read or write burst
`default_nettype none
`timescale 1ns/1ps

module axi_line_master (
  input  logic                    i_aclk,
  input  logic                    i_rst,
  input  logic                    i_req,
  input  line_req_pkg::line_req_t i_req_data,
  output logic                    o_done,
  output line_req_pkg::line_rsp_t o_rsp_data,
  output axi_pkg::axi_aw_t        o_aw,
  output logic                    o_awvalid,
  input  logic                    i_awready,
  output axi_pkg::axi_w_t         o_w,
  output logic                    o_wvalid,
  input  logic                    i_wready,
  input  axi_pkg::axi_resp_e      i_bresp,
  input  logic                    i_bvalid,
  output logic                    o_bready,
  output axi_pkg::axi_ar_t        o_ar,
  output logic                    o_arvalid,
  input  logic                    i_arready,
  input  axi_pkg::axi_r_t         i_r,
  input  logic                    i_rvalid,
  output logic                    o_rready
);
  import axi_pkg::*;
  import line_req_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_AR,
    ST_R,
    ST_AW,
    ST_W,
    ST_B
  } state_e;

  state_e     st_q;
  logic [1:0] beat_q;                            // beat index inside the burst
  logic       err_q;                             // sticky for the current line
  line_addr_t addr_q;
  line_t      buf_q;                             // write data out or read data in
  line_mask_t mask_q;
  axi_ax_t    line_ax;
  logic       aw_fire;
  logic       w_fire;
  logic       b_fire;
  logic       ar_fire;
  logic       r_fire;
  logic       last_beat;
  logic       accept;

  // ----------------------------------------
  // handshakes
  // ----------------------------------------
  assign aw_fire = o_awvalid & i_awready;
  assign w_fire  = o_wvalid & i_wready;
  assign b_fire  = o_bready & i_bvalid;
  assign ar_fire = o_arvalid & i_arready;
  assign r_fire  = o_rready & i_rvalid;

  assign accept    = (st_q == ST_IDLE) && i_req;
  assign last_beat = (beat_q == 2'(AXI_BEATS_PER_LINE - 1));

  assign o_arvalid = (st_q == ST_AR);
  assign o_rready  = (st_q == ST_R);
  assign o_awvalid = (st_q == ST_AW);
  assign o_wvalid  = (st_q == ST_W);
  assign o_bready  = (st_q == ST_B);

  // ----------------------------------------
  // channel payloads
  // ----------------------------------------
  assign line_ax = '{
    addr:  {addr_q, {LINE_OFFSET_W{1'b0}}},    // line aligned
    len:   8'(AXI_BEATS_PER_LINE - 1),
    size:  AXI_SIZE_8B,
    burst: INCR,
    cache: AXI_CACHE_NONE,
    prot:  AXI_PROT_DATA_SEC_UNPRIV
  };
  assign o_aw = line_ax;
  assign o_ar = line_ax;

  assign o_w = '{
    data: buf_q[beat_q*AXI_DATA_W +: AXI_DATA_W],
    strb: mask_q[beat_q*AXI_STRB_W +: AXI_STRB_W],
    last: last_beat
  };

  assign o_rsp_data = '{rdata: buf_q, err: err_q};

  // ----------------------------------------
  // control
  // ----------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      st_q   <= ST_IDLE;
      beat_q <= '0;
      err_q  <= 1'b0;
      o_done <= 1'b0;
    end else begin
      o_done <= (r_fire & i_r.last) | b_fire;  // one cycle after the last handshake
      case (st_q)
        ST_IDLE: begin
          if (i_req) begin
            st_q   <= (i_req_data.op == LINE_WRITE) ? ST_AW : ST_AR;
            beat_q <= '0;
            err_q  <= 1'b0;
          end
        end
        ST_AR: begin
          if (ar_fire) st_q <= ST_R;
        end
        ST_R: begin
          if (r_fire) begin
            beat_q <= beat_q + 2'd1;
            if (i_r.resp != OKAY) err_q <= 1'b1;
            if (i_r.last) st_q <= ST_IDLE;
          end
        end
        ST_AW: begin
          if (aw_fire) st_q <= ST_W;
        end
        ST_W: begin
          if (w_fire) begin
            beat_q <= beat_q + 2'd1;
            if (last_beat) st_q <= ST_B;
          end
        end
        ST_B: begin
          if (b_fire) begin
            if (i_bresp != OKAY) err_q <= 1'b1;
            st_q <= ST_IDLE;
          end
        end
        default: st_q <= ST_IDLE;
      endcase
    end
  end

  // line buffer
  always_ff @(posedge i_aclk) begin
    if (accept) begin
      addr_q <= i_req_data.addr;
      buf_q  <= i_req_data.wdata;
      mask_q <= i_req_data.mask;
    end else if (r_fire) begin
      buf_q[beat_q*AXI_DATA_W +: AXI_DATA_W] <= i_r.data;  // beat k fills bits 64k+63..64k
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_aw_stable: assert property (@(posedge i_aclk) disable iff (i_rst)
    o_awvalid && !i_awready |=> o_awvalid && $stable(o_aw));
  a_w_stable: assert property (@(posedge i_aclk) disable iff (i_rst)
    o_wvalid && !i_wready |=> o_wvalid && $stable(o_w));
  a_ar_stable: assert property (@(posedge i_aclk) disable iff (i_rst)
    o_arvalid && !i_arready |=> o_arvalid && $stable(o_ar));
  a_rlast_fourth: assert property (@(posedge i_aclk) disable iff (i_rst)
    r_fire |-> (i_r.last == last_beat));

endmodule

`default_nettype wire

// File: logic/axi_pkg.sv
// AXI4 widths, channel payload structs and encodings shared by the line master and the memory model
`default_nettype none

package axi_pkg;

  // ----------------------------------------
  // bus widths
  // ----------------------------------------
  localparam int AXI_ADDR_W         = 32;
  localparam int AXI_DATA_W         = 64;
  localparam int AXI_STRB_W         = AXI_DATA_W / 8;
  localparam int AXI_BEATS_PER_LINE = 4;         // one 256-bit line per burst

  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [AXI_STRB_W-1:0] axi_strb_t;

  // ----------------------------------------
  // encodings
  // ----------------------------------------
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,                              // the only burst type in use
    WRAP  = 2'b10
  } axi_burst_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  localparam logic [2:0] AXI_SIZE_8B              = 3'd3;    // 8 bytes per beat
  localparam logic [3:0] AXI_CACHE_NONE           = 4'b0000;
  localparam logic [2:0] AXI_PROT_DATA_SEC_UNPRIV = 3'b000;

  // ----------------------------------------
  // channel payloads
  // ----------------------------------------
  typedef struct packed {
    axi_addr_t  addr;
    logic [7:0] len;                             // beats minus one
    logic [2:0] size;
    axi_burst_e burst;
    logic [3:0] cache;
    logic [2:0] prot;
  } axi_ax_t;

  typedef axi_ax_t axi_aw_t;                     // same layout on both address channels
  typedef axi_ax_t axi_ar_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } axi_w_t;

  typedef struct packed {
    axi_data_t data;
    axi_resp_e resp;
    logic      last;
  } axi_r_t;

endpackage

`default_nettype wire

// File: logic/line_arbiter.sv
// round-robin arbiter that latches both requesters' line strobes and hands one at a time to the master
`default_nettype none
`timescale 1ns/1ps

module line_arbiter (
  input  logic                     i_aclk,
  input  logic                     i_rst,
  input  logic                     i_ic_req,
  input  line_req_pkg::line_addr_t i_ic_addr,
  input  logic                     i_dc_req,
  input  line_req_pkg::line_req_t  i_dc_req_data,
  output logic                     o_mst_req,
  output line_req_pkg::line_req_t  o_mst_req_data,
  input  logic                     i_done,
  input  line_req_pkg::line_rsp_t  i_rsp_data,
  output logic                     o_ic_rsp,
  output line_req_pkg::line_rsp_t  o_ic_rsp_data,
  output logic                     o_dc_rsp,
  output line_req_pkg::line_rsp_t  o_dc_rsp_data
);
  import line_req_pkg::*;

  logic       ic_pend_q;
  logic       dc_pend_q;
  line_addr_t ic_addr_q;
  line_req_t  dc_req_q;
  line_req_t  ic_line_req;
  req_id_e    last_q;                              // port granted most recently
  logic [1:0] own_q;                               // one-hot owner, zero when free
  logic       busy;
  req_id_e    pick;

  assign busy = |own_q;

  // the other port wins a tie
  assign pick = (ic_pend_q && dc_pend_q) ? ((last_q == REQ_ICACHE) ? REQ_DCACHE : REQ_ICACHE)
              : (ic_pend_q ? REQ_ICACHE : REQ_DCACHE);

  assign ic_line_req = '{op: LINE_READ, addr: ic_addr_q, wdata: '0, mask: '0};

  assign o_mst_req_data = own_q[REQ_DCACHE] ? dc_req_q : ic_line_req;

  // ----------------------------------------
  // response routing
  // ----------------------------------------
  assign o_ic_rsp      = i_done & own_q[REQ_ICACHE];
  assign o_dc_rsp      = i_done & own_q[REQ_DCACHE];
  assign o_ic_rsp_data = own_q[REQ_ICACHE] ? i_rsp_data : '0;
  assign o_dc_rsp_data = own_q[REQ_DCACHE] ? i_rsp_data : '0;

  always_ff @(posedge i_aclk) begin
    if (i_ic_req) begin
      ic_addr_q <= i_ic_addr;
    end
    if (i_dc_req) begin
      dc_req_q <= i_dc_req_data;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      ic_pend_q <= 1'b0;
      dc_pend_q <= 1'b0;
      last_q    <= REQ_DCACHE;                      // first tie goes to the icache
      own_q     <= '0;
      o_mst_req <= 1'b0;
    end else begin
      if (i_ic_req) ic_pend_q <= 1'b1;
      else if (o_ic_rsp) ic_pend_q <= 1'b0;
      if (i_dc_req) dc_pend_q <= 1'b1;
      else if (o_dc_rsp) dc_pend_q <= 1'b0;

      o_mst_req <= !busy && (ic_pend_q || dc_pend_q);
      if (!busy && (ic_pend_q || dc_pend_q)) begin
        own_q  <= (pick == REQ_ICACHE) ? 2'b01 : 2'b10;
        last_q <= pick;
      end else if (i_done) begin
        own_q <= '0;                                // free from the next cycle
      end
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_ic_no_overlap: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_ic_req |-> !ic_pend_q);
  a_dc_no_overlap: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_dc_req |-> !dc_pend_q);
  a_done_when_busy: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_done |-> busy);

endmodule

`default_nettype wire

// File: logic/line_req_pkg.sv
// cache-side line request and response types used between the requesters, arbiter and master
`default_nettype none

package line_req_pkg;

  // ----------------------------------------
  // line geometry
  // ----------------------------------------
  localparam int LINE_BYTES    = 32;
  localparam int LINE_W        = LINE_BYTES * 8;
  localparam int LINE_OFFSET_W = 5;                        // byte offset inside a line
  localparam int LINE_ADDR_W   = 32 - LINE_OFFSET_W;       // byte address bits 31..5

  typedef logic [LINE_W-1:0]      line_t;
  typedef logic [LINE_ADDR_W-1:0] line_addr_t;
  typedef logic [LINE_BYTES-1:0]  line_mask_t;

  typedef enum logic {
    LINE_READ  = 1'b0,
    LINE_WRITE = 1'b1
  } line_op_e;

  typedef struct packed {
    line_op_e   op;
    line_addr_t addr;
    line_t      wdata;                         // ignored on reads
    line_mask_t mask;                          // one bit per byte of wdata
  } line_req_t;

  typedef struct packed {
    line_t rdata;
    logic  err;                                // any response other than OKAY
  } line_rsp_t;

  typedef enum logic {
    REQ_ICACHE = 1'b0,
    REQ_DCACHE = 1'b1
  } req_id_e;

endpackage

`default_nettype wire

// File: logic/mem_bus_top.sv
// memory-side bus top joining the icache and dcache line ports to one AXI4 master port
`default_nettype none
`timescale 1ns/1ps

module mem_bus_top (
  input  logic                     i_aclk,
  input  logic                     i_rst,
  // instruction cache port
  input  logic                     i_ic_req,
  input  line_req_pkg::line_addr_t i_ic_addr,
  output logic                     o_ic_rsp,
  output line_req_pkg::line_rsp_t  o_ic_rsp_data,
  // data cache port
  input  logic                     i_dc_req,
  input  line_req_pkg::line_req_t  i_dc_req_data,
  output logic                     o_dc_rsp,
  output line_req_pkg::line_rsp_t  o_dc_rsp_data,
  // AXI4 master port
  output axi_pkg::axi_aw_t         o_aw,
  output logic                     o_awvalid,
  input  logic                     i_awready,
  output axi_pkg::axi_w_t          o_w,
  output logic                     o_wvalid,
  input  logic                     i_wready,
  input  axi_pkg::axi_resp_e       i_bresp,
  input  logic                     i_bvalid,
  output logic                     o_bready,
  output axi_pkg::axi_ar_t         o_ar,
  output logic                     o_arvalid,
  input  logic                     i_arready,
  input  axi_pkg::axi_r_t          i_r,
  input  logic                     i_rvalid,
  output logic                     o_rready
);
  import line_req_pkg::*;

  logic      mst_req;                             // grant strobe to the master
  line_req_t mst_req_data;
  logic      mst_done;
  line_rsp_t mst_rsp_data;

  // ----------------------------------------
  // arbiter
  // ----------------------------------------
  line_arbiter arb0 (
    .i_aclk         (i_aclk),
    .i_rst          (i_rst),
    .i_ic_req       (i_ic_req),
    .i_ic_addr      (i_ic_addr),
    .i_dc_req       (i_dc_req),
    .i_dc_req_data  (i_dc_req_data),
    .o_mst_req      (mst_req),
    .o_mst_req_data (mst_req_data),
    .i_done         (mst_done),
    .i_rsp_data     (mst_rsp_data),
    .o_ic_rsp       (o_ic_rsp),
    .o_ic_rsp_data  (o_ic_rsp_data),
    .o_dc_rsp       (o_dc_rsp),
    .o_dc_rsp_data  (o_dc_rsp_data)
  );

  // ----------------------------------------
  // AXI master
  // ----------------------------------------
  axi_line_master mst0 (
    .i_aclk     (i_aclk),
    .i_rst      (i_rst),
    .i_req      (mst_req),
    .i_req_data (mst_req_data),
    .o_done     (mst_done),
    .o_rsp_data (mst_rsp_data),
    .o_aw       (o_aw),
    .o_awvalid  (o_awvalid),
    .i_awready  (i_awready),
    .o_w        (o_w),
    .o_wvalid   (o_wvalid),
    .i_wready   (i_wready),
    .i_bresp    (i_bresp),
    .i_bvalid   (i_bvalid),
    .o_bready   (o_bready),
    .o_ar       (o_ar),
    .o_arvalid  (o_arvalid),
    .i_arready  (i_arready),
    .i_r        (i_r),
    .i_rvalid   (i_rvalid),
    .o_rready   (o_rready)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the memory bus testbench with Verilator.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal -f build.f --top-module mem_bus_tb -o mem_bus_sim
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

./obj_dir/mem_bus_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
echo "simulation passed"
exit 0
